//--- logic/heapPkg.sv
// Shared types for the fixed-size array heap
// Action codes, error codes and the per-action check result
package heapPkg;

  //--------------------------------------------------
  // Action codes, unlisted values behave as idle
  typedef enum logic [7:0] {
    actIdle       = 8'd0,
    actWrite      = 8'd2,                        // Write element, may grow array
    actRead       = 8'd3,                        // Read element
    actSize       = 8'd4,                        // Current size of array
    actInc        = 8'd5,                        // Grow by one
    actDec        = 8'd6,                        // Shrink by one
    actPush       = 8'd14,                       // Append element
    actPop        = 8'd15,                       // Remove last element
    actAlloc      = 8'd18,                       // Hand out an array
    actFree       = 8'd19,                       // Return an array
    actAdd        = 8'd20,                       // Element ops from here on
    actAddAfter   = 8'd21,                       // Returns old value
    actSubtract   = 8'd22,
    actSubAfter   = 8'd23,                       // Returns old value
    actShiftLeft  = 8'd24,
    actShiftRight = 8'd25,
    actNotLogical = 8'd26,
    actNot        = 8'd27,
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } heapAction_t;

  //--------------------------------------------------
  typedef enum logic [3:0] {
    errNone        = 4'd0,
    errUnallocated = 4'd1,                       // Never handed out
    errFreed       = 4'd2,                       // Handed out, then freed
    errOutOfBounds = 4'd3,                       // Index at or past size
    errFull        = 4'd4,
    errEmpty       = 4'd5,
    errOutOfMemory = 4'd6                        // No array left to allocate
  } heapError_t;

  typedef struct packed {
    logic       ok;                              // Action may proceed
    heapError_t code;                            // errNone when ok
  } heapCheck_t;

  function automatic heapCheck_t makeCheck(heapError_t code);
    return '{ok: code == errNone, code: code};
  endfunction

  function automatic logic isElementOp(heapAction_t action);
    return action >= actAdd && action <= actAnd; // Contiguous code range
  endfunction

endpackage

//--- logic/heapAllocator.sv
// Array allocator for the heap
// Per-array allocated flags, a high-water count of arrays ever handed out,
// and a LIFO of freed array numbers that allocation drains first
`timescale 1ns/100ps

module heapAllocator import heapPkg::*; #(
  parameter int addressBits = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   allocate,       // Hand out allocArray at this edge
  input  logic                   free,           // Return array at this edge
  input  logic [addressBits-1:0] array,          // Array named by the action
  output heapCheck_t             liveCheck,      // Is array currently allocated
  output logic [addressBits-1:0] allocArray,     // Next array to hand out
  output heapCheck_t             allocCheck      // Out of memory or ok
);

  localparam int arrays = 2 ** addressBits;

  logic [arrays-1:0]      allocated;             // One flag per array
  logic [addressBits:0]   highWater;             // Arrays ever handed out
  logic [addressBits:0]   stackTop;              // Entries on freed stack
  logic [addressBits-1:0] freedStack [arrays];   // Freed array numbers
  logic [addressBits-1:0] popIndex;              // Slot of newest freed entry
  logic                   stackEmpty;

  assign stackEmpty = stackTop == '0;
  assign popIndex   = stackTop[addressBits-1:0] - 1'b1;  // Wraps to top slot when full

  //--------------------------------------------------
  // Checks on the requested array
  always_comb begin
    if ({1'b0, array} >= highWater) begin
      liveCheck = makeCheck(errUnallocated);     // Number never reached
    end else if (!allocated[array]) begin
      liveCheck = makeCheck(errFreed);
    end else begin
      liveCheck = makeCheck(errNone);
    end
  end

  // Freed arrays first, LIFO, then fresh ones from the count
  assign allocArray = stackEmpty ? highWater[addressBits-1:0] : freedStack[popIndex];

  always_comb begin
    if (stackEmpty && highWater == (addressBits+1)'(arrays)) begin
      allocCheck = makeCheck(errOutOfMemory);    // Every array in use
    end else begin
      allocCheck = makeCheck(errNone);
    end
  end

  //--------------------------------------------------
  // State update
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated <= '0;
      highWater <= '0;
      stackTop  <= '0;
    end else if (allocate) begin
      allocated[allocArray] <= 1'b1;
      if (stackEmpty) begin
        highWater <= highWater + 1'b1;           // Fresh array
      end else begin
        stackTop <= stackTop - 1'b1;             // Reuse freed array
      end
    end else if (free) begin
      allocated[array] <= 1'b0;
      stackTop         <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (free) begin
      freedStack[stackTop[addressBits-1:0]] <= array;  // Never full while one is live
    end
  end

endmodule

//--- logic/heapSizeTable.sv
// Size table for the heap
// Holds the current size of every array, performs the bounds, full and empty
// checks and applies size changes for the accepted action
`timescale 1ns/100ps

module heapSizeTable import heapPkg::*; #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  heapAction_t            action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  heapCheck_t             liveCheck,      // From allocator
  input  logic                   allocate,       // Successful Alloc this edge
  input  logic [addressBits-1:0] allocArray,     // Array being handed out
  output logic [indexBits:0]     size,           // Size of requested array
  output heapCheck_t             accessCheck     // Live check merged with size checks
);

  localparam int                 arrays  = 2 ** addressBits;
  localparam logic [indexBits:0] maxSize = (indexBits+1)'(2 ** indexBits);

  logic [indexBits:0] sizes [arrays];            // One size per array
  logic [indexBits:0] wideIndex;                 // Index widened to size width
  logic               outOfBounds;
  logic               atFull;
  logic               atEmpty;

  assign size        = sizes[array];
  assign wideIndex   = {1'b0, index};
  assign outOfBounds = wideIndex >= size;
  assign atFull      = size == maxSize;
  assign atEmpty     = size == '0;

  //--------------------------------------------------
  // Checks, live check takes priority
  always_comb begin
    accessCheck = liveCheck;
    if (liveCheck.ok) begin
      case (action)
        actRead: begin
          if (outOfBounds) accessCheck = makeCheck(errOutOfBounds);
        end
        actPush, actInc: begin
          if (atFull) accessCheck = makeCheck(errFull);
        end
        actPop, actDec: begin
          if (atEmpty) accessCheck = makeCheck(errEmpty);
        end
        default: begin
          if (isElementOp(action) && outOfBounds) begin
            accessCheck = makeCheck(errOutOfBounds);  // Ops need an existing element
          end
        end
      endcase
    end
  end

  //--------------------------------------------------
  // Size update
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arrays; i++) begin
        sizes[i] <= '0;
      end
    end else if (allocate) begin
      sizes[allocArray] <= '0;                   // New array starts empty
    end else if (accessCheck.ok) begin
      case (action)
        actWrite: begin
          if (outOfBounds) sizes[array] <= wideIndex + 1'b1;  // Grow to cover index
        end
        actPush, actInc: begin
          sizes[array] <= size + 1'b1;
        end
        actPop, actDec: begin
          sizes[array] <= size - 1'b1;
        end
        default: begin
          // Other actions keep size
        end
      endcase
    end
  end

endmodule

//--- logic/heapElementAlu.sv
// Element ALU for the heap
// Combinational arithmetic and logic on one element, modulo 2^dataBits
`timescale 1ns/100ps

module heapElementAlu import heapPkg::*; #(
  parameter int dataBits = 12
) (
  input  heapAction_t         action,
  input  logic [dataBits-1:0] element,           // Current element value
  input  logic [dataBits-1:0] operand,           // From in port
  output logic [dataBits-1:0] newValue,          // Value written back
  output logic [dataBits-1:0] resultValue        // Value returned on out
);

  logic shiftOver;                               // Shift moves every bit out
  logic returnOld;                               // After variants

  assign shiftOver = operand >= dataBits;
  assign returnOld = action == actAddAfter || action == actSubAfter;

  //--------------------------------------------------
  always_comb begin
    case (action)
      actAdd, actAddAfter: begin
        newValue = element + operand;            // Wraps
      end
      actSubtract, actSubAfter: begin
        newValue = element - operand;            // Wraps
      end
      actShiftLeft: begin
        newValue = shiftOver ? '0 : element << operand;
      end
      actShiftRight: begin
        newValue = shiftOver ? '0 : element >> operand;  // Logical
      end
      actNotLogical: begin
        newValue = dataBits'(element == '0);     // 1 when zero
      end
      actNot: newValue = ~element;
      actOr:  newValue = element | operand;
      actXor: newValue = element ^ operand;
      actAnd: newValue = element & operand;
      default: begin
        newValue = element;                      // Not an element op
      end
    endcase
  end

  assign resultValue = returnOld ? element : newValue;

endmodule

//--- logic/heapStorage.sv
// Element storage for the heap
// One word per array element, combinational read and clocked write
`timescale 1ns/100ps

module heapStorage #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic [addressBits-1:0] array,          // Array number
  input  logic [indexBits-1:0]   elementIndex,   // Element within array
  input  logic                   writeEnable,
  input  logic [dataBits-1:0]    writeData,
  output logic [dataBits-1:0]    readData        // Same-cycle read
);

  localparam int wordBits = addressBits + indexBits;
  localparam int words    = 2 ** wordBits;

  //--------------------------------------------------
  // Arrays laid out in fixed blocks, array number on top
  logic [dataBits-1:0] memory [words];
  logic [wordBits-1:0] wordAddress;

  assign wordAddress = {array, elementIndex};
  assign readData    = memory[wordAddress];      // Sizes guard stale words

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[wordAddress] <= writeData;
    end
  end

endmodule

//--- logic/heapMemory.sv
// Heap of fixed-size arrays, top level
// Accepts one action per clock, registers out and error at the same edge
`timescale 1ns/100ps

module heapMemory import heapPkg::*; #(
  parameter int addressBits = 2,                 // 2^addressBits arrays
  parameter int indexBits   = 2,                 // 2^indexBits elements per array
  parameter int dataBits    = 12                 // Element width
) (
  input  logic                   clock,
  input  logic                   reset,
  input  heapAction_t            action,         // Sampled every edge, idle is no-op
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output heapError_t             error
);

  heapCheck_t             liveCheck;
  heapCheck_t             allocCheck;
  heapCheck_t             accessCheck;
  heapCheck_t             opCheck;               // Check of the current action
  logic [addressBits-1:0] allocArray;
  logic [indexBits:0]     size;
  logic [indexBits-1:0]   elementIndex;
  logic [dataBits-1:0]    readData;
  logic [dataBits-1:0]    newValue;
  logic [dataBits-1:0]    resultValue;
  logic [dataBits-1:0]    result;                // Next out on success
  logic                   active;                // Known non-idle action
  logic                   elementOp;
  logic                   allocate;
  logic                   free;
  logic                   writeEnable;

  //--------------------------------------------------
  // Action decode
  assign elementOp   = isElementOp(action);
  assign allocate    = action == actAlloc && allocCheck.ok;
  assign free        = action == actFree && liveCheck.ok;
  assign writeEnable = opCheck.ok && (action == actWrite || action == actPush || elementOp);

  always_comb begin
    case (action)
      actPop:  elementIndex = indexBits'(size - 1'b1);  // Last element
      actPush: elementIndex = indexBits'(size);         // First free slot
      default: elementIndex = index;
    endcase
  end

  always_comb begin
    active  = 1'b1;
    opCheck = accessCheck;
    result  = out;
    case (action)
      actWrite:                        result = in;
      actRead, actPop:                 result = readData;
      actSize:                         result = dataBits'(size);
      actInc, actDec, actPush, actFree: result = out;  // Out holds
      actAlloc: begin
        opCheck = allocCheck;
        result  = dataBits'(allocArray);
      end
      default: begin
        if (elementOp) result = resultValue;
        else active = 1'b0;                      // Idle and unused codes
      end
    endcase
  end

  //--------------------------------------------------
  heapAllocator #(.addressBits(addressBits)) allocator (
    .clock, .reset, .allocate, .free, .array, .liveCheck, .allocArray, .allocCheck
  );

  heapSizeTable #(.addressBits(addressBits), .indexBits(indexBits)) sizeTable (
    .clock, .reset, .action, .array, .index, .liveCheck, .allocate, .allocArray,
    .size, .accessCheck
  );

  heapElementAlu #(.dataBits(dataBits)) alu (
    .action, .element(readData), .operand(in), .newValue, .resultValue
  );

  heapStorage #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) storage (
    .clock, .array, .elementIndex, .writeEnable,
    .writeData(elementOp ? newValue : in), .readData
  );

  //--------------------------------------------------
  // Result registers, failed actions keep out
  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= errNone;
    end else if (active) begin
      error <= opCheck.code;
      if (opCheck.ok) out <= result;
    end
  end

endmodule

//--- dv/heapClockGen.sv
// Clock and reset source for the heap testbench
// Power-on reset for a fixed number of cycles, plus a reset on request
`timescale 1ns/100ps

module heapClockGen #(
  parameter int halfPeriod  = 4,                 // 8 ns period
  parameter int resetCycles = 16
) (
  input  logic resetRequest,                     // Extra reset from the tests
  output logic clock,
  output logic reset
);

  logic powerOnReset = 1'b1;

  initial begin
    clock = 1'b0;
    forever #(halfPeriod) clock = ~clock;
  end

  initial begin
    repeat (resetCycles) @(posedge clock);
    powerOnReset <= 1'b0;                        // Released after the last reset edge
  end

  assign reset = powerOnReset || resetRequest;

endmodule

//--- dv/heapMemory_chk.sv
// Bound checks on the heap top level
// Error code range, stable outputs over idle cycles, state after reset
`timescale 1ns/100ps

module heapMemory_chk import heapPkg::*; #(
  parameter int dataBits = 12
) (
  input logic                clock,
  input logic                reset,
  input heapAction_t         action,
  input logic [dataBits-1:0] out,
  input heapError_t          error
);

  int failures = 0;                              // Summed into the testbench error count

  //--------------------------------------------------
  errorDefined: assert property (@(posedge clock) disable iff (reset)
    !$isunknown(error) && error <= errOutOfMemory)
  else begin
    failures++;
    $error("error output holds an undefined code %h", error);
  end

  // Idle action leaves both result registers alone
  idleStable: assert property (@(posedge clock) disable iff (reset)
    action == actIdle |=> $stable(out) && $stable(error))
  else begin
    failures++;
    $error("out or error changed after an idle cycle");
  end

  resetClean: assert property (@(posedge clock) $fell(reset) |-> error == errNone)
  else begin
    failures++;
    $error("error not cleared by reset, got %h", error);
  end

endmodule

//--- dv/heapTb.sv
// Testbench for the heap of fixed-size arrays
// Directed tests against a model of contents and the last out value
`timescale 1ns/100ps

module heapTb import heapPkg::*; ();

  localparam int addressBits = 2;
  localparam int indexBits   = 2;
  localparam int dataBits    = 12;
  localparam int cycleLimit  = 3000;             // Tests take about 230 cycles

  logic                   clock;
  logic                   reset;
  logic                   resetRequest;
  heapAction_t            action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    in;
  logic [dataBits-1:0]    out;
  heapError_t             error;

  int                  errorCount;
  int                  cycleCount = 0;
  logic [31:0]         rngState;
  logic [dataBits-1:0] modelOut;                 // Out expected to hold on failure
  logic [dataBits-1:0] modelData [2**addressBits][2**indexBits];

  heapClockGen #(.halfPeriod(4), .resetCycles(16)) clockGen (.resetRequest, .clock, .reset);

  heapMemory #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) i_dut (
    .clock, .reset, .action, .array, .index, .in, .out, .error
  );

  bind heapMemory heapMemory_chk #(.dataBits(dataBits)) chk (
    .clock, .reset, .action, .out, .error
  );

  //--------------------------------------------------
  // Xorshift generator and ALU rules
  function automatic logic [dataBits-1:0] randomData();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState[dataBits-1:0];
  endfunction

  function automatic logic [dataBits-1:0] aluNewValue(heapAction_t op, logic [dataBits-1:0] elem,
                                                      logic [dataBits-1:0] opnd);
    case (op)
      actAdd, actAddAfter:      return elem + opnd;
      actSubtract, actSubAfter: return elem - opnd;
      actShiftLeft:             return (opnd >= 12'd12) ? 12'h000 : elem << opnd;
      actShiftRight:            return (opnd >= 12'd12) ? 12'h000 : elem >> opnd;
      actNotLogical:            return (elem == 12'h000) ? 12'h001 : 12'h000;
      actNot:                   return ~elem;
      actOr:                    return elem | opnd;
      actXor:                   return elem ^ opnd;
      actAnd:                   return elem & opnd;
      default:                  return elem;
    endcase
  endfunction

  //--------------------------------------------------
  // Drive on the falling edge, result read one full edge later
  task automatic issueAction(heapAction_t act, int arr, int idx, logic [dataBits-1:0] value);
    action = act;
    array  = arr[addressBits-1:0];
    index  = idx[indexBits-1:0];
    in     = value;
    @(posedge clock);
    @(negedge clock);
    action = actIdle;
  endtask

  task automatic checkResult(string label, logic [dataBits-1:0] expOut, heapError_t expError);
    assert (error == expError) else begin
      errorCount++;
      $display("MISMATCH error in %s: got 0x%h, expected 0x%h", label, error, expError);
    end
    assert (out == expOut) else begin
      errorCount++;
      $display("MISMATCH out in %s: got 0x%h, expected 0x%h", label, out, expOut);
    end
  endtask

  task automatic expectOk(string label, heapAction_t act, int arr, int idx,
                          logic [dataBits-1:0] value, logic [dataBits-1:0] expOut);
    issueAction(act, arr, idx, value);
    modelOut = expOut;
    checkResult(label, expOut, errNone);
  endtask

  task automatic expectFail(string label, heapAction_t act, int arr, int idx, heapError_t code);
    issueAction(act, arr, idx, 12'h5a5);         // Junk data must not land anywhere
    checkResult(label, modelOut, code);
  endtask

  task automatic resetDut();
    resetRequest = 1'b1;
    repeat (4) @(negedge clock);
    resetRequest = 1'b0;
    modelOut     = '0;
    checkResult("reset", '0, errNone);
  endtask

  //--------------------------------------------------
  task automatic referenceProgram();
    resetDut();
    expectOk("Alloc", actAlloc, 0, 0, '0, 12'h000);
    expectOk("Push 1", actPush, 0, 0, 12'h001, modelOut);
    expectOk("Push 2", actPush, 0, 0, 12'h002, modelOut);
    expectOk("Read 0", actRead, 0, 0, '0, 12'h001);
    expectOk("Read 1", actRead, 0, 1, '0, 12'h002);
    expectOk("Size", actSize, 0, 0, '0, 12'h002);
    expectOk("Pop", actPop, 0, 0, '0, 12'h002);
    expectOk("Size after Pop", actSize, 0, 0, '0, 12'h001);
  endtask

  task automatic allocation();
    resetDut();
    for (int n = 0; n < 4; n++) begin
      expectOk("Alloc fresh", actAlloc, 0, 0, '0, dataBits'(n));
    end
    expectFail("Alloc when full", actAlloc, 0, 0, errOutOfMemory);
    expectOk("Free 2", actFree, 2, 0, '0, modelOut);
    expectOk("Free 1", actFree, 1, 0, '0, modelOut);
    expectOk("Alloc reuse", actAlloc, 0, 0, '0, 12'h001);  // Last freed comes back first
    expectOk("Alloc reuse", actAlloc, 0, 0, '0, 12'h002);
    expectOk("Free 3", actFree, 3, 0, '0, modelOut);
    expectFail("Free twice", actFree, 3, 0, errFreed);
    expectFail("Read freed", actRead, 3, 0, errFreed);
  endtask

  task automatic boundsAndSizes();
    logic [dataBits-1:0] value;
    resetDut();
    expectOk("Alloc", actAlloc, 0, 0, '0, 12'h000);
    expectFail("Pop empty", actPop, 0, 0, errEmpty);
    expectFail("Dec empty", actDec, 0, 0, errEmpty);
    for (int i = 0; i < 3; i++) begin
      modelData[0][i] = randomData();
      expectOk("Push", actPush, 0, 0, modelData[0][i], modelOut);
    end
    expectOk("Read last", actRead, 0, 2, '0, modelData[0][2]);
    expectFail("Read past size", actRead, 0, 3, errOutOfBounds);
    expectOk("Inc", actInc, 0, 0, '0, modelOut);
    expectOk("Size after Inc", actSize, 0, 0, '0, 12'h004);
    expectFail("Push full", actPush, 0, 0, errFull);
    expectFail("Inc full", actInc, 0, 0, errFull);
    value = randomData();
    expectOk("Alloc", actAlloc, 0, 0, '0, 12'h001);
    expectOk("Write past size", actWrite, 1, 3, value, value);
    expectOk("Size after Write", actSize, 1, 0, '0, 12'h004);
    expectOk("Read written", actRead, 1, 3, '0, value);
    expectOk("Dec", actDec, 1, 0, '0, modelOut);
    expectFail("Read after Dec", actRead, 1, 3, errOutOfBounds);
  endtask

  task automatic elementOps();
    heapAction_t         op;
    int                  idx;
    logic [dataBits-1:0] operand;
    logic [dataBits-1:0] newValue;
    logic [dataBits-1:0] oldValue;
    resetDut();
    expectOk("Alloc", actAlloc, 0, 0, '0, 12'h000);
    for (int i = 0; i < 4; i++) begin
      modelData[0][i] = randomData();
      expectOk("Write", actWrite, 0, i, modelData[0][i], modelData[0][i]);
    end
    for (int round = 0; round < 6; round++) begin
      for (int code = actAdd; code <= actAnd; code++) begin
        op       = heapAction_t'(code);
        idx      = int'(randomData() % 4);
        operand  = randomData();
        if (op == actShiftLeft || op == actShiftRight) operand = operand % 16;  // Some past width
        oldValue = modelData[0][idx];
        newValue = aluNewValue(op, oldValue, operand);
        expectOk(op.name(), op, 0, idx, operand,
                 (op == actAddAfter || op == actSubAfter) ? oldValue : newValue);
        modelData[0][idx] = newValue;
        expectOk("Read after op", actRead, 0, idx, '0, newValue);
      end
    end
    expectOk("Alloc", actAlloc, 0, 0, '0, 12'h001);
    expectFail("Op on empty array", actAdd, 1, 0, errOutOfBounds);
    expectFail("Op on unallocated array", actXor, 3, 0, errUnallocated);
  endtask

  task automatic resetBehavior();
    expectOk("Alloc before reset", actAlloc, 0, 0, '0, 12'h002);
    expectOk("Write before reset", actWrite, 2, 0, 12'h3c3, 12'h3c3);
    expectFail("Read before reset", actRead, 2, 1, errOutOfBounds);  // Leaves error set
    repeat (3) @(negedge clock);                 // Idle stretch for the checker
    resetDut();
    expectFail("Read after reset", actRead, 0, 0, errUnallocated);
    expectOk("Alloc after reset", actAlloc, 0, 0, '0, 12'h000);
  endtask

  //--------------------------------------------------
  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run exceeded %0d cycles", cycleLimit);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    rngState     = 32'd35202;
    errorCount   = 0;
    modelOut     = '0;
    resetRequest = 1'b0;
    action       = actIdle;
    array        = '0;
    index        = '0;
    in           = '0;
    @(negedge reset);
    @(negedge clock);
    referenceProgram();
    allocation();
    boundsAndSizes();
    elementOps();
    resetBehavior();
    errorCount += i_dut.chk.failures;
    $display("Checks done, %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
logic/heapPkg.sv
logic/heapAllocator.sv
logic/heapSizeTable.sv
logic/heapElementAlu.sv
logic/heapStorage.sv
logic/heapMemory.sv
dv/heapClockGen.sv
dv/heapMemory_chk.sv
dv/heapTb.sv

//--- Makefile
# Verilator build and run for the array heap

VERILATOR ?= verilator
TOP       ?= heapTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
